// File: source/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int XLEN      = 32;
    localparam int NREG_BITS = 5;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [NREG_BITS-1:0] reg_idx_t;

    // RV32I major opcodes in use
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    // ALU_LINK writes pc + 4
    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_XOR, ALU_LINK} alu_op_t;

    typedef enum logic [1:0] {KIND_ALU, KIND_JAL, KIND_BEQ, KIND_BNE} instr_kind_t;

    typedef enum logic [1:0] {PC_SEQ, PC_JUMP, PC_BRANCH} pc_sel_t;

    typedef struct packed {
        logic        valid;
        word_t       pc;
        logic [31:0] instr;
    } if_id_t;

    typedef struct packed {
        logic        valid;
        word_t       pc;
        instr_kind_t kind;
        alu_op_t     alu_op;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        reg_idx_t    rd;
        logic        we;
        logic        use_imm;
        word_t       imm;
    } id_rr_t;

    typedef struct packed {
        id_rr_t dec;
        word_t  rs1_data;
        word_t  rs2_data;
    } rr_exe_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        logic     we;
        word_t    result;
    } exe_wb_t;

endpackage

`default_nettype wire

// File: source/pipe_ctrl_if.sv
`default_nettype none

interface pipe_ctrl_if import core_pkg::*; ();

    logic    stall_fetch;
    logic    flush_id;
    logic    flush_rr;
    logic    flush_exe;
    pc_sel_t pc_sel;

    // Control unit side
    modport cu (
        output stall_fetch, flush_id, flush_rr, flush_exe, pc_sel
    );

    modport stage (
        input stall_fetch, flush_id, flush_rr, flush_exe, pc_sel
    );

endinterface

`default_nettype wire

// File: source/fetch_stage.sv
`default_nettype none

module fetch_stage
    import core_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  logic        clk_i,
    input  logic        rstn_i,
    pipe_ctrl_if.stage  ctrl,
    input  word_t       jump_target_i,
    input  word_t       branch_target_i,
    output word_t       imem_addr_o,
    input  logic [31:0] imem_rdata_i,
    output if_id_t      if_id_o
);

    word_t pc_q;
    word_t pc_d;

    // Redirects win over the debug stall
    always_comb begin
        case (ctrl.pc_sel)
            PC_JUMP:   pc_d = jump_target_i;
            PC_BRANCH: pc_d = branch_target_i;
            default:   pc_d = ctrl.stall_fetch ? pc_q : pc_q + word_t'(4);
        endcase
    end

    assign imem_addr_o = pc_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q    <= RESET_PC;
            if_id_o <= '0;
        end else begin
            pc_q          <= pc_d;
            // Bubble when halted or when decode redirects
            if_id_o.valid <= !(ctrl.stall_fetch || ctrl.flush_id);
            if_id_o.pc    <= pc_q;
            if_id_o.instr <= imem_rdata_i;
        end
    end

endmodule

`default_nettype wire

// File: source/decode_stage.sv
`default_nettype none

module decode_stage
    import core_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  if_id_t     if_id_i,
    pipe_ctrl_if.stage ctrl,
    output logic       jal_taken_o,
    output word_t      jump_target_o,
    output id_rr_t     id_rr_o
);

    logic [31:0] instr;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    word_t       imm_i;
    word_t       imm_j;
    word_t       imm_b;
    logic        legal;
    id_rr_t      id_d;

    assign instr  = if_id_i.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Sign-extended immediates
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    assign jal_taken_o   = if_id_i.valid && (opcode == OPC_JAL);
    assign jump_target_o = if_id_i.pc + imm_j;

    always_comb begin
        legal        = 1'b0;
        id_d         = '0;
        id_d.pc      = if_id_i.pc;
        id_d.rs1     = instr[19:15];
        id_d.rs2     = instr[24:20];
        id_d.rd      = instr[11:7];
        id_d.kind    = KIND_ALU;
        id_d.alu_op  = ALU_ADD;
        case (opcode)
            OPC_OP: begin
                id_d.we = 1'b1;
                if (funct3 == F3_ADD_SUB && funct7 == F7_BASE) begin
                    legal = 1'b1;
                end else if (funct3 == F3_ADD_SUB && funct7 == F7_SUB) begin
                    legal       = 1'b1;
                    id_d.alu_op = ALU_SUB;
                end else if (funct3 == F3_XOR && funct7 == F7_BASE) begin
                    legal       = 1'b1;
                    id_d.alu_op = ALU_XOR;
                end
            end
            OPC_OP_IMM: begin
                legal        = (funct3 == F3_ADD_SUB);
                id_d.we      = 1'b1;
                id_d.use_imm = 1'b1;
                id_d.imm     = imm_i;
            end
            OPC_JAL: begin
                legal       = 1'b1;
                id_d.we     = 1'b1;
                id_d.kind   = KIND_JAL;
                id_d.alu_op = ALU_LINK;
                id_d.imm    = imm_j;
            end
            OPC_BRANCH: begin
                legal       = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
                id_d.kind   = (funct3 == F3_BEQ) ? KIND_BEQ : KIND_BNE;
                id_d.alu_op = ALU_SUB;
                id_d.imm    = imm_b;
            end
            default: ;
        endcase
        // Unsupported encodings travel on as bubbles
        id_d.valid = if_id_i.valid && legal;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            id_rr_o <= '0;
        end else begin
            id_rr_o <= id_d;
            if (ctrl.flush_rr) begin
                id_rr_o.valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/regfile.sv
`default_nettype none

module regfile
    import core_pkg::*;
(
    input  logic     clk_i,
    input  logic     rstn_i,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    output word_t    rdata1_o,
    output word_t    rdata2_o,
    input  exe_wb_t  wb_i,
    input  logic     dbg_halt_i,
    input  logic     dbg_wr_i,
    input  reg_idx_t dbg_addr_i,
    input  word_t    dbg_wdata_i,
    output word_t    dbg_rdata_o
);

    localparam int NUM_REGS = 2 ** NREG_BITS;

    // x0 has no storage
    word_t    regs [1:NUM_REGS-1];
    logic     dbg_wr;
    logic     wr_en;
    reg_idx_t wr_addr;
    word_t    wr_data;

    // Debug write takes the single write port while halted
    assign dbg_wr  = dbg_halt_i && dbg_wr_i;
    assign wr_en   = dbg_wr || (wb_i.valid && wb_i.we);
    assign wr_addr = dbg_wr ? dbg_addr_i : wb_i.rd;
    assign wr_data = dbg_wr ? dbg_wdata_i : wb_i.result;

    // Port-1 style read with write-through
    function automatic word_t read_reg(input reg_idx_t idx);
        word_t value;
        if (idx == '0) begin
            value = '0;
        end else if (wr_en && wr_addr == idx) begin
            value = wr_data;
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    always_comb begin
        rdata1_o    = read_reg(rs1_i);
        rdata2_o    = read_reg(rs2_i);
        dbg_rdata_o = read_reg(dbg_addr_i);
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: source/execute_stage.sv
`default_nettype none

module execute_stage
    import core_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  id_rr_t     id_rr_i,
    input  word_t      rdata1_i,
    input  word_t      rdata2_i,
    pipe_ctrl_if.stage ctrl,
    output logic       branch_taken_o,
    output word_t      branch_target_o,
    output exe_wb_t    wb_o
);

    rr_exe_t exe_q;
    logic    fwd_ok;
    word_t   op_a;
    word_t   rs2_val;
    word_t   op_b;
    word_t   alu_res;
    logic    eq;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            exe_q <= '0;
        end else begin
            exe_q.dec      <= id_rr_i;
            exe_q.rs1_data <= rdata1_i;
            exe_q.rs2_data <= rdata2_i;
            if (ctrl.flush_exe) begin
                exe_q.dec.valid <= 1'b0;
            end
        end
    end

    // Bypass from the instruction now in write-back
    assign fwd_ok  = wb_o.valid && wb_o.we && (wb_o.rd != '0);
    assign op_a    = (fwd_ok && wb_o.rd == exe_q.dec.rs1) ? wb_o.result : exe_q.rs1_data;
    assign rs2_val = (fwd_ok && wb_o.rd == exe_q.dec.rs2) ? wb_o.result : exe_q.rs2_data;
    assign op_b    = exe_q.dec.use_imm ? exe_q.dec.imm : rs2_val;

    always_comb begin
        case (exe_q.dec.alu_op)
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_LINK: alu_res = exe_q.dec.pc + word_t'(4);
            default:  alu_res = op_a + op_b;
        endcase
    end

    // Branch resolution
    assign eq              = (op_a == rs2_val);
    assign branch_taken_o  = exe_q.dec.valid &&
                             ((exe_q.dec.kind == KIND_BEQ && eq) ||
                              (exe_q.dec.kind == KIND_BNE && !eq));
    assign branch_target_o = exe_q.dec.pc + exe_q.dec.imm;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wb_o <= '0;
        end else begin
            wb_o.valid  <= exe_q.dec.valid;
            wb_o.pc     <= exe_q.dec.pc;
            wb_o.rd     <= exe_q.dec.rd;
            wb_o.we     <= exe_q.dec.we;
            // Branches retire with a zero result
            wb_o.result <= exe_q.dec.we ? alu_res : '0;
        end
    end

endmodule

`default_nettype wire

// File: source/control_unit.sv
`default_nettype none

module control_unit
    import core_pkg::*;
(
    input  logic    jal_taken_i,
    input  logic    branch_taken_i,
    input  logic    dbg_halt_i,
    pipe_ctrl_if.cu ctrl
);

    always_comb begin
        ctrl.stall_fetch = dbg_halt_i;
        ctrl.flush_id    = 1'b0;
        ctrl.flush_rr    = 1'b0;
        ctrl.flush_exe   = 1'b0;
        ctrl.pc_sel      = PC_SEQ;
        if (branch_taken_i) begin
            // Branch in execute kills everything younger
            ctrl.pc_sel    = PC_BRANCH;
            ctrl.flush_id  = 1'b1;
            ctrl.flush_rr  = 1'b1;
            ctrl.flush_exe = 1'b1;
        end else if (jal_taken_i) begin
            // Only the word being fetched is wrong path
            ctrl.pc_sel   = PC_JUMP;
            ctrl.flush_id = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/core_top.sv
`default_nettype none

module core_top
    import core_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  logic        clk_i,
    input  logic        rstn_i,
    output word_t       imem_addr_o,
    input  logic [31:0] imem_rdata_i,
    input  logic        dbg_halt_i,
    input  logic        dbg_wr_i,
    input  reg_idx_t    dbg_addr_i,
    input  word_t       dbg_wdata_i,
    output word_t       dbg_rdata_o,
    output logic        commit_valid_o,
    output word_t       commit_pc_o,
    output reg_idx_t    commit_rd_o,
    output logic        commit_we_o,
    output word_t       commit_data_o
);

    if_id_t  if_id;
    id_rr_t  id_rr;
    exe_wb_t wb;
    logic    jal_taken;
    word_t   jump_target;
    logic    branch_taken;
    word_t   branch_target;
    word_t   rdata1;
    word_t   rdata2;

    pipe_ctrl_if ctrl_if ();

    control_unit control_unit_i (
        .jal_taken_i    (jal_taken),
        .branch_taken_i (branch_taken),
        .dbg_halt_i     (dbg_halt_i),
        .ctrl           (ctrl_if.cu)
    );

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) fetch_stage_i (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .ctrl            (ctrl_if.stage),
        .jump_target_i   (jump_target),
        .branch_target_i (branch_target),
        .imem_addr_o     (imem_addr_o),
        .imem_rdata_i    (imem_rdata_i),
        .if_id_o         (if_id)
    );

    decode_stage decode_stage_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .if_id_i       (if_id),
        .ctrl          (ctrl_if.stage),
        .jal_taken_o   (jal_taken),
        .jump_target_o (jump_target),
        .id_rr_o       (id_rr)
    );

    regfile regfile_i (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .rs1_i       (id_rr.rs1),
        .rs2_i       (id_rr.rs2),
        .rdata1_o    (rdata1),
        .rdata2_o    (rdata2),
        .wb_i        (wb),
        .dbg_halt_i  (dbg_halt_i),
        .dbg_wr_i    (dbg_wr_i),
        .dbg_addr_i  (dbg_addr_i),
        .dbg_wdata_i (dbg_wdata_i),
        .dbg_rdata_o (dbg_rdata_o)
    );

    execute_stage execute_stage_i (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .id_rr_i         (id_rr),
        .rdata1_i        (rdata1),
        .rdata2_i        (rdata2),
        .ctrl            (ctrl_if.stage),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .wb_o            (wb)
    );

    // Commit trace is the write-back register
    assign commit_valid_o = wb.valid;
    assign commit_pc_o    = wb.pc;
    assign commit_rd_o    = wb.rd;
    assign commit_we_o    = wb.we;
    assign commit_data_o  = wb.result;

endmodule

`default_nettype wire

// File: tests/core_tb.sv
`default_nettype none

module core_tb
    import core_pkg::*;
();

    localparam word_t RESET_PC   = 32'h0000_0100;
    localparam word_t HALT_PC    = 32'h0000_0164;
    localparam int    ROM_WORDS  = 26;
    localparam int    DBG_STEPS  = 12;
    localparam int    MAX_CYCLES = 16 + 4 * (ROM_WORDS + DBG_STEPS) + 50;
    // Opcode zero is not a supported encoding
    localparam logic [31:0] INVALID_WORD = 32'h0000_0000;

    typedef struct packed {
        word_t    pc;
        reg_idx_t rd;
        logic     we;
        word_t    data;
    } commit_row_t;

    logic        clk_i = 1'b0;
    logic        rstn_i;
    word_t       imem_addr_o;
    logic [31:0] imem_rdata_i;
    logic        dbg_halt_i;
    logic        dbg_wr_i;
    reg_idx_t    dbg_addr_i;
    word_t       dbg_wdata_i;
    word_t       dbg_rdata_o;
    logic        commit_valid_o;
    word_t       commit_pc_o;
    reg_idx_t    commit_rd_o;
    logic        commit_we_o;
    word_t       commit_data_o;

    logic [31:0] rom [ROM_WORDS];
    commit_row_t expected [$];
    int          rom_index;
    int          commit_idx   = 0;
    int          cycle_count  = 0;
    logic        halted_quiet = 1'b0;

    core_top #(
        .RESET_PC (RESET_PC)
    ) core_top_i (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .imem_addr_o    (imem_addr_o),
        .imem_rdata_i   (imem_rdata_i),
        .dbg_halt_i     (dbg_halt_i),
        .dbg_wr_i       (dbg_wr_i),
        .dbg_addr_i     (dbg_addr_i),
        .dbg_wdata_i    (dbg_wdata_i),
        .dbg_rdata_o    (dbg_rdata_o),
        .commit_valid_o (commit_valid_o),
        .commit_pc_o    (commit_pc_o),
        .commit_rd_o    (commit_rd_o),
        .commit_we_o    (commit_we_o),
        .commit_data_o  (commit_data_o)
    );

    always #5 clk_i = ~clk_i;

    // Instruction memory answers in the same cycle
    always_comb begin
        rom_index = int'((imem_addr_o - RESET_PC) >> 2);
        if (imem_addr_o >= RESET_PC && imem_addr_o[1:0] == 2'b00 && rom_index < ROM_WORDS) begin
            imem_rdata_i = rom[rom_index];
        end else begin
            imem_rdata_i = INVALID_WORD;
        end
    end

    // RV32I encoders
    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [2:0] f3,
                                               input reg_idx_t rd, input reg_idx_t rs1,
                                               input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi_word(input reg_idx_t rd, input reg_idx_t rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] jal_word(input reg_idx_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] branch_word(input logic [2:0] f3, input reg_idx_t rs1,
                                                input reg_idx_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic stop_with_failure();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            $display("error at %0t: %s expected %0d got %0d", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error at %0t: %s expected %b got %b", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic add_expected(input word_t pc, input reg_idx_t rd, input logic we,
                                input word_t data);
        commit_row_t row;
        row = '{pc, rd, we, data};
        expected.push_back(row);
    endtask

    task automatic load_program();
        rom[0]  = addi_word(5'd1, 5'd0, 12'd5);
        rom[1]  = addi_word(5'd2, 5'd1, 12'd7);
        rom[2]  = rtype_word(7'b0000000, 3'b000, 5'd3, 5'd1, 5'd2);
        rom[3]  = rtype_word(7'b0100000, 3'b000, 5'd4, 5'd3, 5'd1);
        rom[4]  = rtype_word(7'b0000000, 3'b100, 5'd5, 5'd4, 5'd3);
        rom[5]  = addi_word(5'd0, 5'd1, 12'd9);
        rom[6]  = rtype_word(7'b0000000, 3'b000, 5'd6, 5'd0, 5'd1);
        rom[7]  = rtype_word(7'b0100000, 3'b000, 5'd7, 5'd0, 5'd1);
        rom[8]  = jal_word(5'd8, 21'd12);
        rom[9]  = addi_word(5'd9, 5'd0, 12'd1);
        rom[10] = addi_word(5'd9, 5'd0, 12'd2);
        rom[11] = branch_word(3'b000, 5'd1, 5'd3, 13'd8);
        rom[12] = branch_word(3'b001, 5'd2, 5'd4, 13'd8);
        rom[13] = branch_word(3'b000, 5'd2, 5'd4, 13'd16);
        rom[14] = addi_word(5'd9, 5'd0, 12'd3);
        rom[15] = addi_word(5'd9, 5'd0, 12'd4);
        rom[16] = addi_word(5'd9, 5'd0, 12'd5);
        rom[17] = addi_word(5'd10, 5'd0, 12'd3);
        rom[18] = branch_word(3'b001, 5'd10, 5'd1, 13'd16);
        rom[19] = addi_word(5'd9, 5'd0, 12'd6);
        rom[20] = addi_word(5'd9, 5'd0, 12'd7);
        rom[21] = addi_word(5'd9, 5'd0, 12'd8);
        rom[22] = rtype_word(7'b0000000, 3'b000, 5'd11, 5'd10, 5'd7);
        rom[23] = rtype_word(7'b0000000, 3'b100, 5'd12, 5'd11, 5'd1);
        rom[24] = addi_word(5'd13, 5'd12, 12'd1);
        // x15 comes from the debug port
        rom[25] = rtype_word(7'b0000000, 3'b000, 5'd16, 5'd15, 5'd13);
    endtask

    // Branch rows carry no destination register
    task automatic load_expected();
        add_expected(32'h0000_0100, 5'd1, 1'b1, 32'h0000_0005);
        add_expected(32'h0000_0104, 5'd2, 1'b1, 32'h0000_000C);
        add_expected(32'h0000_0108, 5'd3, 1'b1, 32'h0000_0011);
        add_expected(32'h0000_010C, 5'd4, 1'b1, 32'h0000_000C);
        add_expected(32'h0000_0110, 5'd5, 1'b1, 32'h0000_001D);
        add_expected(32'h0000_0114, 5'd0, 1'b1, 32'h0000_000E);
        add_expected(32'h0000_0118, 5'd6, 1'b1, 32'h0000_0005);
        add_expected(32'h0000_011C, 5'd7, 1'b1, 32'hFFFF_FFFB);
        add_expected(32'h0000_0120, 5'd8, 1'b1, 32'h0000_0124);
        add_expected(32'h0000_012C, 5'd0, 1'b0, 32'h0000_0000);
        add_expected(32'h0000_0130, 5'd0, 1'b0, 32'h0000_0000);
        add_expected(32'h0000_0134, 5'd0, 1'b0, 32'h0000_0000);
        add_expected(32'h0000_0144, 5'd10, 1'b1, 32'h0000_0003);
        add_expected(32'h0000_0148, 5'd0, 1'b0, 32'h0000_0000);
        add_expected(32'h0000_0158, 5'd11, 1'b1, 32'hFFFF_FFFE);
        add_expected(32'h0000_015C, 5'd12, 1'b1, 32'hFFFF_FFFB);
        add_expected(32'h0000_0160, 5'd13, 1'b1, 32'hFFFF_FFFC);
        add_expected(32'h0000_0164, 5'd16, 1'b1, 32'h0000_0FFC);
    endtask

    // Commit monitor samples away from the rising edge
    always @(negedge clk_i) begin
        if (rstn_i && commit_valid_o) begin
            if (halted_quiet) begin
                $display("commit of pc %h appeared while fetch was halted", commit_pc_o);
                stop_with_failure();
            end else if (commit_idx >= expected.size()) begin
                $display("unexpected extra commit of pc %h", commit_pc_o);
                stop_with_failure();
            end else begin
                check_word("commit_pc_o", expected[commit_idx].pc, commit_pc_o);
                check_bit("commit_we_o", expected[commit_idx].we, commit_we_o);
                if (expected[commit_idx].we) begin
                    check_reg("commit_rd_o", expected[commit_idx].rd, commit_rd_o);
                    check_word("commit_data_o", expected[commit_idx].data, commit_data_o);
                end
                commit_idx = commit_idx + 1;
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout after %0d cycles with %0d commits seen", cycle_count, commit_idx);
            stop_with_failure();
        end
    end

    initial begin
        rstn_i      = 1'b0;
        dbg_halt_i  = 1'b0;
        dbg_wr_i    = 1'b0;
        dbg_addr_i  = '0;
        dbg_wdata_i = '0;
        load_program();
        load_expected();
        repeat (16) begin
            @(posedge clk_i);
            #1;
            check_bit("commit_valid_o", 1'b0, commit_valid_o);
        end
        rstn_i = 1'b1;
        check_word("imem_addr_o", RESET_PC, imem_addr_o);

        // Halt just as the last instruction is being fetched
        while (imem_addr_o !== HALT_PC) begin
            @(posedge clk_i);
            #1;
        end
        dbg_halt_i = 1'b1;
        repeat (4) @(posedge clk_i);
        #1;
        halted_quiet = 1'b1;
        repeat (4) @(posedge clk_i);
        #1;
        dbg_wr_i    = 1'b1;
        dbg_addr_i  = 5'd15;
        dbg_wdata_i = 32'h0000_1000;
        @(posedge clk_i);
        #1;
        dbg_wr_i = 1'b0;
        #1;
        check_word("dbg_rdata_o", 32'h0000_1000, dbg_rdata_o);
        @(posedge clk_i);
        #1;
        dbg_addr_i = 5'd5;
        #1;
        check_word("dbg_rdata_o", 32'h0000_001D, dbg_rdata_o);
        check_word("imem_addr_o", HALT_PC, imem_addr_o);
        @(posedge clk_i);
        #1;
        halted_quiet = 1'b0;
        dbg_halt_i   = 1'b0;

        while (commit_idx < expected.size()) begin
            @(posedge clk_i);
        end
        // Anything after the last row is caught by the monitor
        repeat (8) @(posedge clk_i);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
source/core_pkg.sv
source/pipe_ctrl_if.sv
source/fetch_stage.sv
source/decode_stage.sv
source/regfile.sv
source/execute_stage.sv
source/control_unit.sv
source/core_top.sv
tests/core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check for a pass"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "NO ERRORS"

clean:
	rm -rf $(BUILD_DIR)
